/* verilog/fdc_cfg.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC core configuration
// Step timing in clk cycles, sector size, retry limit and
// host register addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FDC_CFG_SVH
`define FDC_CFG_SVH

// Step pulse low time and gap before next step
`define FDC_STEP_PULSE 4
`define FDC_STEP_RATE 16
// Data field length, small for simulation
`define FDC_SECTOR_BYTES 16
// Index pulses before record not found
`define FDC_INDEX_RETRIES 5
// Host register map
`define FDC_A_CMD 2'd0
`define FDC_A_TRACK 2'd1
`define FDC_A_SECTOR 2'd2
`define FDC_A_DATA 2'd3

`endif

/* verilog/fdc_cmd_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC command package
// Command classes decoded from the command byte and the
// status byte with its type I and type II views
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fdc_cmd_pkg;

	// Command class, taken from the high nibble
	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_RESTORE,
		CMD_SEEK,
		CMD_STEP_IN,
		CMD_STEP_OUT,
		CMD_READ_SECTOR,
		CMD_FORCE_INT
	} cmd_kind_e;

	// Bit 0 of the high nibble is the update flag on step commands
	function automatic cmd_kind_e decode_cmd(logic [7:0] cmd);
		case (cmd[7:4])
			4'h0: return CMD_RESTORE;
			4'h1: return CMD_SEEK;
			4'h4, 4'h5: return CMD_STEP_IN;
			4'h6, 4'h7: return CMD_STEP_OUT;
			4'h8, 4'h9: return CMD_READ_SECTOR;
			4'hD: return CMD_FORCE_INT;
			default: return CMD_NONE;
		endcase
	endfunction

	// Type I view, head positioning
	typedef struct packed {
		logic not_ready;
		logic wprot;
		logic head_loaded;
		logic seek_err;
		logic crc_err;
		logic track0;
		logic index;
		logic busy;
	} status_type1_t;

	// Type II view, sector read
	typedef struct packed {
		logic not_ready;
		logic zero;
		logic record_type;
		logic rnf;
		logic crc_err;
		logic lost_data;
		logic drq;
		logic busy;
	} status_type2_t;

	// Same byte, decoded by the last command type
	typedef union packed {
		logic [7:0] raw;
		status_type1_t t1;
		status_type2_t t2;
	} status_t;

endpackage

/* verilog/fdc_disk_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC disk side package
// Framed byte from the read stream and address mark codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fdc_disk_pkg;

	// One byte from the framer
	typedef struct packed {
		logic [7:0] data;
		// One cycle strobe
		logic valid;
		// First byte after sync
		logic mark;
	} disk_byte_t;

	// Three A1 bytes in front of every mark
	localparam logic [23:0] SYNC_WORD = 24'hA1A1A1;

	// Mark bytes following the sync
	localparam logic [7:0] MARK_IDAM = 8'hFE;
	localparam logic [7:0] MARK_DAM = 8'hFB;
	localparam logic [7:0] MARK_DDAM = 8'hF8;

endpackage

/* verilog/fdc_cmd_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC command interface
// Command, registers and engine status between the host
// register block and the seek and read engines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface fdc_cmd_if (
	input logic clk
);
	// Register block side
	logic [7:0] cmd;
	logic start;
	logic [7:0] track;
	logic [7:0] sector;
	logic [7:0] data;

	// Seek engine side
	logic seek_busy;
	logic track_load;
	logic [7:0] track_value;
	logic seek_done;
	logic seek_err;

	// Read engine side
	logic read_busy;
	logic push;
	logic [7:0] push_byte;
	logic read_done;
	logic rnf;
	logic record_type;

	modport regs (
		input clk,
		output cmd, start, track, sector, data,
		input seek_busy, track_load, track_value, seek_done, seek_err,
		input read_busy, push, push_byte, read_done, rnf, record_type
	);

	modport seek (
		input clk, cmd, start, track, data,
		output seek_busy, track_load, track_value, seek_done, seek_err
	);

	modport read (
		input clk, cmd, start, track, sector,
		output read_busy, push, push_byte, read_done, rnf, record_type
	);

endinterface

/* verilog/fdc_byte_framer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC byte framer
// Finds the A1 A1 A1 sync in the serial read stream and
// delivers bytes, flagging the first one after sync as mark
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fdc_byte_framer import fdc_disk_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rd_bit,
	input logic rd_bit_valid,
	input logic index_n,
	output disk_byte_t byte_out
);

	logic [23:0] window;
	logic [23:0] window_next;
	logic [2:0] bit_cnt;
	logic locked;
	logic mark_arm;

	// Window as it looks after the current bit
	assign window_next = {window[22:0], rd_bit};

	always_ff @(posedge clk) begin
		byte_out.valid <= 1'b0;
		if (rst) begin
			window <= '0;
			bit_cnt <= '0;
			locked <= 1'b0;
			mark_arm <= 1'b0;
			byte_out.mark <= 1'b0;
		end else begin
			if (rd_bit_valid) begin
				window <= window_next;
				if (window_next == SYNC_WORD) begin
					// Sync found, realign byte boundary
					bit_cnt <= '0;
					locked <= 1'b1;
					mark_arm <= 1'b1;
				end else if (locked) begin
					bit_cnt <= bit_cnt + 3'd1;
					// Eighth bit completes a byte
					if (bit_cnt == 3'd7) begin
						byte_out.data <= window_next[7:0];
						byte_out.valid <= 1'b1;
						byte_out.mark <= mark_arm;
						mark_arm <= 1'b0;
					end
				end
			end
			// Index hole ends the current track pass
			if (!index_n)
				locked <= 1'b0;
		end
	end

endmodule

/* verilog/fdc_host_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC host register block
// Bus edge decode, command/track/sector/data registers,
// one byte read buffer with DRQ and lost data, and status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "fdc_cfg.svh"

module fdc_host_regs import fdc_cmd_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cs_n,
	input logic re_n,
	input logic we_n,
	input logic [1:0] addr,
	input logic [7:0] din,
	output logic [7:0] dout,
	output logic drq,
	output logic intrq,
	input logic ready_n,
	input logic wprot_n,
	input logic trk00_n,
	input logic index_n,
	fdc_cmd_if.regs cif
);

	logic re_q, we_q;
	logic wr_edge, rd_edge;
	logic busy;
	logic cmd_ok;
	logic type2;
	logic lost_data;
	logic [7:0] cmd_r, track_r, sector_r, data_r;
	status_t status;

	assign cif.cmd = cmd_r;
	assign cif.track = track_r;
	assign cif.sector = sector_r;
	assign cif.data = data_r;

	// Strobe falling edges, qualified by chip select
	assign wr_edge = !cs_n && we_q && !we_n;
	assign rd_edge = !cs_n && re_q && !re_n;
	// Start counts as busy until the engine catches up
	assign busy = cif.start | cif.seek_busy | cif.read_busy;
	// Force interrupt is taken even while busy
	assign cmd_ok = wr_edge && addr == `FDC_A_CMD &&
		(!busy || decode_cmd(din) == CMD_FORCE_INT);

	// Command register, start pulse and status view select
	always_ff @(posedge clk) begin
		re_q <= re_n;
		we_q <= we_n;
		cif.start <= 1'b0;
		if (rst) begin
			re_q <= 1'b1;
			we_q <= 1'b1;
			// Restore on the way out of reset
			cmd_r <= 8'h00;
			cif.start <= 1'b1;
			type2 <= 1'b0;
		end else if (cmd_ok) begin
			cmd_r <= din;
			cif.start <= 1'b1;
			if (decode_cmd(din) != CMD_FORCE_INT)
				type2 <= (decode_cmd(din) == CMD_READ_SECTOR);
		end
	end

	// Track, sector and data registers with the read buffer
	always_ff @(posedge clk) begin
		if (rst) begin
			track_r <= 8'd0;
			sector_r <= 8'd1;
			data_r <= 8'd0;
			drq <= 1'b0;
			lost_data <= 1'b0;
		end else begin
			if (wr_edge && addr == `FDC_A_TRACK && !busy)
				track_r <= din;
			// Engine update beats a host write
			if (cif.track_load)
				track_r <= cif.track_value;
			if (wr_edge && addr == `FDC_A_SECTOR && !busy)
				sector_r <= din;
			if (wr_edge && addr == `FDC_A_DATA)
				data_r <= din;
			if (rd_edge && addr == `FDC_A_DATA)
				drq <= 1'b0;
			if (cmd_ok) begin
				drq <= 1'b0;
				lost_data <= 1'b0;
			end
			// Unread byte gets overwritten
			if (cif.push) begin
				data_r <= cif.push_byte;
				drq <= 1'b1;
				if (drq)
					lost_data <= 1'b1;
			end
		end
	end

	// INTRQ set after an engine finishes
	always_ff @(posedge clk) begin
		if (rst)
			intrq <= 1'b0;
		else if (cif.seek_done || cif.read_done)
			intrq <= 1'b1;
		else if (cmd_ok || (rd_edge && addr == `FDC_A_CMD))
			intrq <= 1'b0;
	end

	// Status byte through the view of the last command
	always_comb begin
		status.raw = '0;
		if (type2) begin
			status.t2.not_ready = ready_n;
			status.t2.record_type = cif.record_type;
			status.t2.rnf = cif.rnf;
			status.t2.lost_data = lost_data;
			status.t2.drq = drq;
			status.t2.busy = busy;
		end else begin
			// Live drive pins
			status.t1.not_ready = ready_n;
			status.t1.wprot = !wprot_n;
			status.t1.seek_err = cif.seek_err;
			status.t1.track0 = !trk00_n;
			status.t1.index = !index_n;
			status.t1.busy = busy;
		end
	end

	// Read mux, bus idles high
	always_comb begin
		dout = 8'hFF;
		if (!cs_n && !re_n) begin
			case (addr)
				`FDC_A_CMD: dout = status.raw;
				`FDC_A_TRACK: dout = track_r;
				`FDC_A_SECTOR: dout = sector_r;
				`FDC_A_DATA: dout = data_r;
				default: dout = 8'hFF;
			endcase
		end
	end

endmodule

/* verilog/fdc_seek_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC seek controller
// Type I engine for restore, seek and step in/out, driving
// step and direction and reporting the new track
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "fdc_cfg.svh"

module fdc_seek_ctrl import fdc_cmd_pkg::*; (
	input logic clk,
	input logic rst,
	input logic trk00_n,
	output logic step_n,
	output logic dir_n,
	fdc_cmd_if.seek cif
);

	localparam logic [7:0] PULSE_LAST = 8'(`FDC_STEP_PULSE - 1);
	localparam logic [7:0] RATE_LAST = 8'(`FDC_STEP_RATE - 1);

	// Check, direction setup, pulse, settle
	typedef enum logic [2:0] {S_IDLE, S_CHECK, S_SETUP, S_PULSE, S_WAIT} state_e;

	state_e state;
	cmd_kind_e kind;
	logic [7:0] cur_track;
	logic [7:0] target;
	logic [7:0] steps;
	logic [7:0] timer;
	logic update;

	assign step_n = (state != S_PULSE);
	assign cif.seek_busy = (state != S_IDLE);

	always_ff @(posedge clk) begin
		cif.track_load <= 1'b0;
		cif.seek_done <= 1'b0;
		if (rst) begin
			state <= S_IDLE;
			dir_n <= 1'b1;
			cif.seek_err <= 1'b0;
		end else if (cif.start) begin
			kind <= decode_cmd(cif.cmd);
			update <= cif.cmd[4];
			cur_track <= cif.track;
			// Seek target sits in the data register
			target <= cif.data;
			steps <= '0;
			case (decode_cmd(cif.cmd))
				CMD_RESTORE, CMD_SEEK, CMD_STEP_IN, CMD_STEP_OUT: begin
					state <= S_CHECK;
					cif.seek_err <= 1'b0;
				end
				CMD_FORCE_INT: state <= S_IDLE;
				default: state <= state;
			endcase
		end else begin
			case (state)
				S_CHECK: begin
					timer <= '0;
					state <= S_SETUP;
					case (kind)
						CMD_RESTORE: begin
							if (!trk00_n) begin
								cif.track_load <= 1'b1;
								cif.track_value <= 8'd0;
								cif.seek_done <= 1'b1;
								state <= S_IDLE;
							end else if (steps == 8'hFF) begin
								// Track 0 never seen
								cif.seek_err <= 1'b1;
								cif.seek_done <= 1'b1;
								state <= S_IDLE;
							end else begin
								dir_n <= 1'b1;
								steps <= steps + 8'd1;
							end
						end
						CMD_SEEK: begin
							if (cur_track == target) begin
								cif.track_load <= 1'b1;
								cif.track_value <= target;
								cif.seek_done <= 1'b1;
								state <= S_IDLE;
							end else begin
								// dir_n low steps toward higher tracks
								dir_n <= (target < cur_track);
								cur_track <= (target < cur_track) ?
									cur_track - 8'd1 : cur_track + 8'd1;
							end
						end
						CMD_STEP_IN, CMD_STEP_OUT: begin
							if (steps != 8'd0) begin
								// Single step taken
								cif.track_load <= update;
								cif.track_value <= cur_track;
								cif.seek_done <= 1'b1;
								state <= S_IDLE;
							end else begin
								dir_n <= (kind == CMD_STEP_OUT);
								cur_track <= (kind == CMD_STEP_OUT) ?
									cur_track - 8'd1 : cur_track + 8'd1;
								steps <= 8'd1;
							end
						end
						default: state <= S_IDLE;
					endcase
				end
				// Direction settles one cycle ahead of the pulse
				S_SETUP: state <= S_PULSE;
				S_PULSE: begin
					timer <= timer + 8'd1;
					if (timer == PULSE_LAST) begin
						timer <= '0;
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					timer <= timer + 8'd1;
					if (timer == RATE_LAST)
						state <= S_CHECK;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* verilog/fdc_sector_reader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC sector reader
// Type II engine, matches the ID field against the track and
// sector registers and pushes the data field to the buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "fdc_cfg.svh"

module fdc_sector_reader import fdc_cmd_pkg::*, fdc_disk_pkg::*; (
	input logic clk,
	input logic rst,
	input logic index_n,
	input logic ready_n,
	input disk_byte_t byte_in,
	fdc_cmd_if.read cif
);

	localparam logic [7:0] LAST_BYTE = 8'(`FDC_SECTOR_BYTES - 1);
	localparam logic [3:0] LAST_RETRY = 4'(`FDC_INDEX_RETRIES - 1);

	typedef enum logic [2:0] {R_IDLE, R_WAIT_ID, R_ID, R_WAIT_DAM, R_DATA, R_FINISH} state_e;

	state_e state;
	logic [2:0] id_idx;
	logic track_ok;
	logic sector_ok;
	logic [7:0] byte_cnt;
	logic [3:0] index_cnt;
	logic index_q;
	logic index_fall;
	logic searching;

	assign cif.read_busy = (state != R_IDLE);
	assign index_fall = index_q && !index_n;
	// Index pulses only count while looking for the sector
	assign searching = (state == R_WAIT_ID || state == R_ID || state == R_WAIT_DAM);

	always_ff @(posedge clk) begin
		index_q <= index_n;
		cif.push <= 1'b0;
		cif.read_done <= 1'b0;
		if (rst) begin
			state <= R_IDLE;
			cif.rnf <= 1'b0;
			cif.record_type <= 1'b0;
		end else if (cif.start) begin
			index_cnt <= '0;
			case (decode_cmd(cif.cmd))
				CMD_READ_SECTOR: begin
					cif.rnf <= 1'b0;
					cif.record_type <= 1'b0;
					// Drive not ready ends right away
					state <= ready_n ? R_FINISH : R_WAIT_ID;
				end
				CMD_FORCE_INT: state <= R_IDLE;
				default: state <= state;
			endcase
		end else if (searching && index_fall && index_cnt == LAST_RETRY) begin
			cif.rnf <= 1'b1;
			state <= R_FINISH;
		end else begin
			if (searching && index_fall)
				index_cnt <= index_cnt + 4'd1;
			case (state)
				R_WAIT_ID: begin
					if (byte_in.valid && byte_in.mark && byte_in.data == MARK_IDAM) begin
						id_idx <= '0;
						state <= R_ID;
					end
				end
				R_ID: begin
					// Track, side, sector, size, two CRC bytes
					if (byte_in.valid) begin
						id_idx <= id_idx + 3'd1;
						if (id_idx == 3'd0)
							track_ok <= (byte_in.data == cif.track);
						if (id_idx == 3'd2)
							sector_ok <= (byte_in.data == cif.sector);
						if (id_idx == 3'd5)
							state <= (track_ok && sector_ok) ? R_WAIT_DAM : R_WAIT_ID;
					end
				end
				R_WAIT_DAM: begin
					if (byte_in.valid && byte_in.mark) begin
						byte_cnt <= '0;
						if (byte_in.data == MARK_DAM || byte_in.data == MARK_DDAM) begin
							cif.record_type <= (byte_in.data == MARK_DDAM);
							state <= R_DATA;
						end else if (byte_in.data == MARK_IDAM) begin
							id_idx <= '0;
							state <= R_ID;
						end
					end
				end
				R_DATA: begin
					if (byte_in.valid) begin
						cif.push <= 1'b1;
						cif.push_byte <= byte_in.data;
						byte_cnt <= byte_cnt + 8'd1;
						if (byte_cnt == LAST_BYTE)
							state <= R_FINISH;
					end
				end
				R_FINISH: begin
					cif.read_done <= 1'b1;
					state <= R_IDLE;
				end
				default: state <= R_IDLE;
			endcase
		end
	end

endmodule

/* verilog/fdc_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC core top level
// Host register block with seek and sector read engines fed
// by the byte framer on the serial read stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fdc_top import fdc_disk_pkg::*; (
	input logic clk,
	input logic rst,
	// Host bus
	input logic cs_n,
	input logic re_n,
	input logic we_n,
	input logic [1:0] addr,
	input logic [7:0] din,
	output logic [7:0] dout,
	output logic drq,
	output logic intrq,
	// Drive
	output logic step_n,
	output logic dir_n,
	input logic index_n,
	input logic trk00_n,
	input logic ready_n,
	input logic wprot_n,
	// Separated read data
	input logic rd_bit,
	input logic rd_bit_valid
);

	disk_byte_t disk_byte;

	fdc_cmd_if cif (.clk(clk));

	fdc_byte_framer u_framer (
		.clk(clk),
		.rst(rst),
		.rd_bit(rd_bit),
		.rd_bit_valid(rd_bit_valid),
		.index_n(index_n),
		.byte_out(disk_byte)
	);

	fdc_host_regs u_regs (
		.clk(clk),
		.rst(rst),
		.cs_n(cs_n),
		.re_n(re_n),
		.we_n(we_n),
		.addr(addr),
		.din(din),
		.dout(dout),
		.drq(drq),
		.intrq(intrq),
		.ready_n(ready_n),
		.wprot_n(wprot_n),
		.trk00_n(trk00_n),
		.index_n(index_n),
		.cif(cif.regs)
	);

	fdc_seek_ctrl u_seek (
		.clk(clk),
		.rst(rst),
		.trk00_n(trk00_n),
		.step_n(step_n),
		.dir_n(dir_n),
		.cif(cif.seek)
	);

	fdc_sector_reader u_reader (
		.clk(clk),
		.rst(rst),
		.index_n(index_n),
		.ready_n(ready_n),
		.byte_in(disk_byte),
		.cif(cif.read)
	);

endmodule

/* verif/fdc_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FDC core testbench
// Runs the opcode script from the test data file against the
// DUT, with a head position model and a serial bit source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "fdc_cfg.svh"

module fdc_tb import fdc_cmd_pkg::*; ();

	logic clk, rst;
	logic cs_n, re_n, we_n;
	logic [1:0] addr;
	logic [7:0] din, dout;
	logic drq, intrq;
	logic step_n, dir_n;
	logic index_n, trk00_n, ready_n, wprot_n;
	logic rd_bit, rd_bit_valid;

	// Head model state
	logic [7:0] head_pos;
	logic [7:0] step_cnt;
	logic last_dir;
	// Bytes waiting for the serializer
	logic [7:0] tx_q[$];
	logic [7:0] tx_cur;
	integer tx_i;
	integer cycles;
	integer limit;

	fdc_top UUT (
		.clk(clk), .rst(rst),
		.cs_n(cs_n), .re_n(re_n), .we_n(we_n),
		.addr(addr), .din(din), .dout(dout),
		.drq(drq), .intrq(intrq),
		.step_n(step_n), .dir_n(dir_n),
		.index_n(index_n), .trk00_n(trk00_n),
		.ready_n(ready_n), .wprot_n(wprot_n),
		.rd_bit(rd_bit), .rd_bit_valid(rd_bit_valid)
	);

	always #20 clk = ~clk;

	// Head follows each falling step edge, dir_n low moves inward
	always @(negedge step_n) begin
		step_cnt <= step_cnt + 8'd1;
		last_dir <= dir_n;
		head_pos <= dir_n ? head_pos - 8'd1 : head_pos + 8'd1;
	end
	assign trk00_n = (head_pos != 8'd0);

	// Serializer, MSB first, one bit every two cycles
	always begin
		@(posedge clk);
		if (tx_q.size() != 0) begin
			tx_cur = tx_q.pop_front();
			for (tx_i = 7; tx_i >= 0; tx_i = tx_i - 1) begin
				#2;
				rd_bit = tx_cur[tx_i];
				rd_bit_valid = 1'b1;
				@(posedge clk);
				#2;
				rd_bit_valid = 1'b0;
				// Next byte picks up on the following edge
				if (tx_i != 0)
					@(posedge clk);
			end
		end
	end

	// Run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("timeout after %0d cycles, DUT never finished", cycles);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	task automatic check_byte(input logic [8*24-1:0] name, input logic [7:0] exp,
		input logic [7:0] act);
		if (act !== exp) begin
			$display("mismatch %0s expected %h actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_status(input logic [8*24-1:0] name, input status_t exp,
		input status_t act);
		if (act.raw !== exp.raw) begin
			$display("mismatch %0s expected %h actual %h", name, exp.raw, act.raw);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_level(input logic [8*24-1:0] name, input logic exp,
		input logic act);
		if (act !== exp) begin
			$display("mismatch %0s expected %b actual %b", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		@(posedge clk);
		#2;
		cs_n = 1'b0;
		addr = a;
		din = d;
		we_n = 1'b0;
		@(posedge clk);
		#2;
		we_n = 1'b1;
		cs_n = 1'b1;
		@(posedge clk);
	endtask

	// Sample dout mid cycle, before the edge that sees re_n fall
	task automatic bus_read(input logic [1:0] a, output logic [7:0] d);
		@(posedge clk);
		#2;
		cs_n = 1'b0;
		addr = a;
		re_n = 1'b0;
		#10;
		d = dout;
		@(posedge clk);
		#2;
		re_n = 1'b1;
		cs_n = 1'b1;
	endtask

	task automatic index_pulse();
		@(posedge clk);
		#2;
		index_n = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		index_n = 1'b1;
		repeat (4) @(posedge clk);
	endtask

	task automatic wait_drq();
		while (drq !== 1'b1)
			@(posedge clk);
	endtask

	// Parse the script; dry pass only sums the cycle budget
	task automatic run_file(input logic dry);
		integer fd;
		integer r;
		logic [8*8-1:0] op;
		logic [8*24-1:0] name;
		logic [8*120-1:0] line;
		logic [7:0] a, v, n, k, d;
		status_t st;
		logic more;
		// A command runs until its INTRQ is seen
		logic pending;
		// Track value the script last expected
		logic [7:0] track_exp;
		fd = $fopen("verif/fdc_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			$display("TEST FAILED");
			$fatal(1);
		end
		// Restore runs out of reset
		pending = 1'b1;
		track_exp = 8'd0;
		more = 1'b1;
		while (more) begin
			r = $fscanf(fd, "%s", op);
			if (r != 1) begin
				more = 1'b0;
			end else if (op == "#") begin
				r = $fgets(line, fd);
			end else if (op == "wr") begin
				r = $fscanf(fd, "%h %h", a, v);
				if (dry)
					limit = limit + 24;
				else
					bus_write(a[1:0], v);
				if (a[1:0] == `FDC_A_TRACK && !pending)
					track_exp = v;
				else if (a[1:0] == `FDC_A_TRACK) begin
					// Engine running, the write must not land
					if (dry)
						limit = limit + 24;
					else begin
						bus_read(`FDC_A_TRACK, d);
						check_byte("busy_track_write", track_exp, d);
					end
				end
				if (a[1:0] == `FDC_A_CMD)
					pending = (v[7:4] != 4'hD);
			end else if (op == "rd") begin
				r = $fscanf(fd, "%h %h %s", a, v, name);
				if (a[1:0] == `FDC_A_TRACK)
					track_exp = v;
				if (dry)
					limit = limit + 24;
				else begin
					bus_read(a[1:0], d);
					check_byte(name, v, d);
				end
			end else if (op == "st") begin
				r = $fscanf(fd, "%h %s", v, name);
				if (dry)
					limit = limit + 24;
				else begin
					bus_read(`FDC_A_CMD, d);
					st.raw = v;
					check_status(name, st, status_t'(d));
				end
			end else if (op == "wi") begin
				pending = 1'b0;
				if (!dry)
					while (intrq !== 1'b1)
						@(posedge clk);
			end else if (op == "iq") begin
				r = $fscanf(fd, "%h %s", v, name);
				if (!dry) begin
					// Leave room for a done pulse to reach INTRQ
					repeat (4) @(posedge clk);
					#2;
					check_level(name, v[0], intrq);
				end
			end else if (op == "sy") begin
				// Three A1 sync bytes
				if (dry)
					limit = limit + 48;
				else
					repeat (3) tx_q.push_back(8'hA1);
			end else if (op == "by") begin
				r = $fscanf(fd, "%h", n);
				for (k = 0; k < n; k = k + 1) begin
					r = $fscanf(fd, "%h", v);
					if (dry)
						limit = limit + 16;
					else
						tx_q.push_back(v);
				end
			end else if (op == "ramp") begin
				r = $fscanf(fd, "%h %h", n, v);
				for (k = 0; k < n; k = k + 1) begin
					if (dry)
						limit = limit + 16;
					else
						tx_q.push_back(v + k);
				end
			end else if (op == "ix") begin
				if (dry)
					limit = limit + 24;
				else
					index_pulse();
			end else if (op == "dq") begin
				r = $fscanf(fd, "%h %h %s", n, v, name);
				for (k = 0; k < n; k = k + 1) begin
					if (dry)
						limit = limit + 24;
					else begin
						wait_drq();
						bus_read(`FDC_A_DATA, d);
						check_byte(name, v + k, d);
					end
				end
			end else if (op == "sk") begin
				// Let the next byte land on top of an unread one
				if (dry)
					limit = limit + 24;
				else begin
					wait_drq();
					repeat (20) @(posedge clk);
				end
			end else if (op == "hp") begin
				r = $fscanf(fd, "%h %s", v, name);
				if (!dry)
					check_byte(name, v, head_pos);
			end else if (op == "sc") begin
				r = $fscanf(fd, "%h %s", v, name);
				if (dry)
					limit = limit + v * (`FDC_STEP_PULSE + `FDC_STEP_RATE + 2);
				else begin
					check_byte(name, v, step_cnt);
					step_cnt = 8'd0;
				end
			end else if (op == "dr") begin
				r = $fscanf(fd, "%h %s", v, name);
				if (!dry)
					check_level(name, v[0], last_dir);
			end else begin
				$display("unknown opcode %0s in the test data file", op);
				$display("TEST FAILED");
				$fatal(1);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cs_n = 1'b1;
		re_n = 1'b1;
		we_n = 1'b1;
		addr = 2'd0;
		din = 8'd0;
		index_n = 1'b1;
		ready_n = 1'b0;
		wprot_n = 1'b1;
		rd_bit = 1'b0;
		rd_bit_valid = 1'b0;
		// Head parked away from track 0
		head_pos = 8'd7;
		step_cnt = 8'd0;
		last_dir = 1'b0;
		cycles = 0;
		limit = 0;
		run_file(1'b1);
		limit = limit + 500;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		run_file(1'b0);
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* project.f */
+incdir+verilog
verilog/fdc_cmd_pkg.sv
verilog/fdc_disk_pkg.sv
verilog/fdc_cmd_if.sv
verilog/fdc_byte_framer.sv
verilog/fdc_host_regs.sv
verilog/fdc_seek_ctrl.sv
verilog/fdc_sector_reader.sv
verilog/fdc_top.sv
verif/fdc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the FDC testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module fdc_tb -f project.f -o fdc_sim \
	&& ./obj_dir/fdc_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1

/* verif/fdc_testdata.txt */
# Columns: opcode, then hex arguments, then a test name on checking lines
# wr a d / rd a exp / st exp / dq n first / by n bytes / ramp n first / hp sc dr iq exp
wi
st 04 restore_status
rd 1 00 restore_track
rd 2 01 restore_sector
hp 00 restore_head
sc 07 restore_steps
dr 1 restore_dir
# Seek to track 5
wr 3 05
wr 0 10
wi
rd 1 05 seek_track
hp 05 seek_head
sc 05 seek_steps
dr 0 seek_dir
# Step in without track update
wr 0 40
wi
rd 1 05 stepin_track
hp 06 stepin_head
sc 01 stepin_steps
# Register rules
wr 2 03
rd 2 03 sector_readback
wr 1 06
rd 1 06 track_readback
wr 3 02
wr 0 10
wr 1 33
wr 0 50
wi
rd 1 02 busy_track
hp 02 busy_head
sc 04 busy_steps
dr 1 busy_dir
# Read sector with DAM
wr 0 80
sy
by 7 FE 02 00 03 01 00 00
sy
by 1 FB
ramp 10 10
by 2 00 00
dq 10 10 read_data
wi
st 00 read_status
# Read with DDAM and one skipped byte
wr 0 80
sy
by 7 FE 02 00 03 01 00 00
sy
by 1 F8
ramp 10 40
by 2 00 00
dq 3 40 ddam_head
sk
dq C 44 ddam_tail
wi
st 24 ddam_lost_status
# Record not found
wr 0 80
sy
by 7 FE 09 00 03 01 00 00
ix
ix
ix
ix
ix
wi
st 10 rnf_status
# Force interrupt during a read
wr 0 80
wr 0 D0
iq 0 force_intrq
st 00 force_status
